/* all.f */
+incdir+rtl
rtl/pci_target_pkg.sv
rtl/pci_target_ctrl.sv
rtl/pci_req_addr.sv
rtl/pci_read_hold.sv
rtl/pci_target_top.sv
tb/pci_target_properties.sv
tb/pci_target_tb.sv

/* Makefile */
.PHONY: compile run clean

LOG = sim.log

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module pci_target_tb -o pci_target_sim

run: compile
	./obj_dir/pci_target_sim | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb/pci_target_tb.sv */
// PCI target testbench
// Table-driven initiator and downstream model
`timescale 1ns/1ns
`default_nettype none

`include "pci_target_params.svh"

module pci_target_tb;

	localparam int NROWS = 10;

	logic                  PCI_CLK;
	logic                  PCI_RSTn;
	logic                  frame_n, irdy_n, idsel;
	logic [`PCI_CBE_W-1:0] cbe_n;
	logic [`PCI_AD_W-1:0]  ad_in;
	wire                   devsel_n, trdy_n, ad_oe;
	wire  [`PCI_AD_W-1:0]  ad_out;
	wire                   cfg_read, cfg_write, mem_read, mem_write;
	wire  [1:0]            cfg_type;
	wire  [5:0]            cfg_dwnum;
	wire  [2:0]            cfg_func;
	wire  [4:0]            cfg_dev;
	wire  [7:0]            cfg_bus;
	wire  [`PCI_CBE_W-1:0] cfg_cbe_n, mem_cbe_n;
	wire  [`PCI_AD_W-1:0]  cfg_writedata, mem_writedata, mem_addr;
	logic [`PCI_AD_W-1:0]  cfg_readdata, mem_readdata;
	logic                  cfg_readdatavalid, mem_readdatavalid;

	// Stimulus table
	logic [3:0]  row_cmd   [NROWS];
	logic [31:0] row_addr  [NROWS];
	logic        row_idsel [NROWS];
	int          row_burst [NROWS];
	logic [31:0] row_data  [NROWS];
	int          row_lat   [NROWS]; // Max downstream latency
	int          row_bp    [NROWS]; // IRDY stall cycles per beat
	logic        row_claim [NROWS];
	logic [3:0]  row_be    [NROWS];

	int errors, cycles, cycle_limit;
	int n_rd, n_wr;   // Downstream strobe totals
	int cur_lat;
	logic [31:0] rd_addr_q [$]; // Pending read addresses
	logic        rd_cfg_q  [$];
	int          rd_lat_q  [$];

	pci_target_top u_pci_target_top (.*);

	// ==============================
	// Clock and watchdog
	// ==============================
	initial begin
		PCI_CLK = 1'b0;
		forever #20 PCI_CLK = ~PCI_CLK;
	end

	always @(posedge PCI_CLK) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout, transactions did not finish within %0d cycles", cycle_limit);
			$display("sim failed");
			$finish;
		end
	end

	// ==============================
	// Downstream model
	// ==============================
	// Strobes are combinational from posedge drives, so sample them mid-cycle
	always @(negedge PCI_CLK) begin
		if (cfg_read | mem_read) begin
			n_rd = n_rd + 1;
			rd_cfg_q.push_back(cfg_read);
			rd_addr_q.push_back(cfg_read ?
				{8'h00, cfg_bus, cfg_dev, cfg_func, cfg_dwnum, cfg_type} : mem_addr);
			rd_lat_q.push_back($urandom % (cur_lat + 1));
		end
		if (cfg_write | mem_write)
			n_wr = n_wr + 1;
	end

	int          mdl_cnt;
	logic        mdl_busy, mdl_cfg;
	logic [31:0] mdl_addr;

	always @(posedge PCI_CLK) begin
		cfg_readdatavalid <= 1'b0; // Valid is a single-cycle pulse
		mem_readdatavalid <= 1'b0;
		if (!mdl_busy && rd_addr_q.size() > 0) begin
			mdl_addr = rd_addr_q.pop_front();
			mdl_cfg  = rd_cfg_q.pop_front();
			mdl_cnt  = rd_lat_q.pop_front();
			mdl_busy = 1'b1;
		end
		if (mdl_busy) begin
			if (mdl_cnt == 0) begin
				mdl_busy = 1'b0;
				if (mdl_cfg) begin
					cfg_readdata      <= mdl_addr ^ 32'h5a5a0000;
					cfg_readdatavalid <= 1'b1;
				end else begin
					mem_readdata      <= mdl_addr ^ 32'h5a5a0000;
					mem_readdatavalid <= 1'b1;
				end
			end else begin
				mdl_cnt = mdl_cnt - 1;
			end
		end
	end

	// ==============================
	// Helpers
	// ==============================
	task automatic check_value(input string msg, input logic [31:0] got,
	                           input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %h expected %h", $time, msg, got, exp);
			errors = errors + 1;
		end
	endtask

	task automatic set_row(input int r, input logic [3:0] cmd, input logic [31:0] addr,
	                       input logic sel, input int burst, input logic [31:0] data,
	                       input int lat, input int bp, input logic claim,
	                       input logic [3:0] be);
		row_cmd[r]   = cmd;
		row_addr[r]  = addr;
		row_idsel[r] = sel;
		row_burst[r] = burst;
		row_data[r]  = data;
		row_lat[r]   = lat;
		row_bp[r]    = bp;
		row_claim[r] = claim;
		row_be[r]    = be;
	endtask

	// Address of beat b with the config dword number wrapping in 6 bits
	function automatic logic [31:0] beat_addr(input logic [31:0] a, input logic is_cfg,
	                                          input int b);
		logic [5:0] dw;
		dw = a[7:2] + b[5:0];
		if (is_cfg)
			return {a[31:8], dw, a[1:0]};
		return a + 32'd4 * b;
	endfunction

	task automatic run_row(input int r);
		int          b, stall, rd0, wr0;
		logic        last, done, is_cfg, is_wr;
		logic [31:0] ea;
		is_cfg = (row_cmd[r] == `PCI_CMD_CFGRD) || (row_cmd[r] == `PCI_CMD_CFGWR);
		is_wr  = (row_cmd[r] == `PCI_CMD_CFGWR) || (row_cmd[r] == `PCI_CMD_MEMWR);
		cur_lat = row_lat[r];
		rd0 = n_rd;
		wr0 = n_wr;
		@(posedge PCI_CLK); // Address phase
		frame_n <= 1'b0;
		ad_in   <= row_addr[r];
		cbe_n   <= row_cmd[r];
		idsel   <= row_idsel[r];
		irdy_n  <= 1'b1;
		if (!row_claim[r]) begin
			@(posedge PCI_CLK);
			ad_in  <= '0;
			cbe_n  <= row_be[r];
			idsel  <= 1'b0;
			irdy_n <= 1'b0;
			repeat (3) begin
				@(negedge PCI_CLK);
				check_value("devsel_n on unclaimed row", devsel_n, 1'b1);
			end
		end else begin
			for (b = 0; b < row_burst[r]; b++) begin
				last = (b == row_burst[r] - 1);
				ea   = beat_addr(row_addr[r], is_cfg, b);
				@(posedge PCI_CLK);
				cbe_n   <= row_be[r];
				idsel   <= 1'b0;
				ad_in   <= is_wr ? row_data[r] + b : '0;
				irdy_n  <= (row_bp[r] != 0);
				frame_n <= (row_bp[r] == 0) ? last : 1'b0;
				stall = 0;
				done  = 1'b0;
				while (!done) begin
					@(negedge PCI_CLK);
					check_value("devsel_n in claimed transaction", devsel_n, 1'b0);
					if (!trdy_n && !irdy_n) begin
						done = 1'b1;
						if (is_wr && is_cfg) begin
							check_value("cfg_write", cfg_write, 1'b1);
							check_value("cfg address", {8'h00, cfg_bus, cfg_dev, cfg_func,
								cfg_dwnum, cfg_type}, ea);
							check_value("cfg_writedata", cfg_writedata, row_data[r] + b);
							check_value("cfg_cbe_n", cfg_cbe_n, row_be[r]);
						end else if (is_wr) begin
							check_value("mem_write", mem_write, 1'b1);
							check_value("mem_addr", mem_addr, ea);
							check_value("mem_writedata", mem_writedata, row_data[r] + b);
							check_value("mem_cbe_n", mem_cbe_n, row_be[r]);
						end else begin
							check_value("ad_out read data", ad_out, ea ^ 32'h5a5a0000);
							check_value("ad_oe in read", ad_oe, 1'b1);
						end
					end else begin
						if (!trdy_n) begin
							stall = stall + 1;
							check_value("strobe in stall",
								cfg_read | mem_read | cfg_write | mem_write, 1'b0);
						end
						if (irdy_n && stall >= row_bp[r]) begin
							@(posedge PCI_CLK);
							irdy_n  <= 1'b0;
							frame_n <= last;
						end
					end
				end
			end
		end
		@(posedge PCI_CLK); // Release the bus
		frame_n <= 1'b1;
		irdy_n  <= 1'b1;
		cbe_n   <= '0;
		ad_in   <= '0;
		@(negedge PCI_CLK);
		check_value("devsel_n after transaction", devsel_n, 1'b1);
		check_value("read strobes", n_rd - rd0, (row_claim[r] && !is_wr) ? row_burst[r] : 0);
		check_value("write strobes", n_wr - wr0, (row_claim[r] && is_wr) ? row_burst[r] : 0);
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		int r;
		void'($urandom(32'h6c77));
		errors   = 0;
		cycles   = 0;
		n_rd     = 0;
		n_wr     = 0;
		cur_lat  = 0;
		mdl_busy = 1'b0;
		mdl_cnt  = 0;
		mdl_cfg  = 1'b0;
		mdl_addr = '0;
		PCI_RSTn = 1'b0;
		frame_n  = 1'b1;
		irdy_n   = 1'b1;
		idsel    = 1'b0;
		cbe_n    = '0;
		ad_in    = '0;
		cfg_readdata      = '0;
		mem_readdata      = '0;
		cfg_readdatavalid = 1'b0;
		mem_readdatavalid = 1'b0;
		//       cmd             addr          sel burst data        lat bp claim be
		set_row(0, `PCI_CMD_MEMWR, 32'h00001000, 0, 4, 32'h11110000, 0, 0, 1, 4'h0);
		set_row(1, `PCI_CMD_MEMWR, 32'h20000040, 0, 2, 32'h22220000, 0, 2, 1, 4'hc);
		set_row(2, `PCI_CMD_CFGWR, 32'h00001910, 1, 3, 32'h33330000, 0, 0, 1, 4'h0);
		set_row(3, `PCI_CMD_CFGWR, 32'h00053af9, 0, 3, 32'h44440000, 0, 1, 1, 4'h3);
		set_row(4, `PCI_CMD_CFGWR, 32'h00000820, 0, 1, 32'h55550000, 0, 0, 0, 4'h0);
		set_row(5, `PCI_CMD_MEMRD, 32'h00003000, 0, 4, 32'h0,        3, 0, 1, 4'h0);
		set_row(6, `PCI_CMD_MEMRD, 32'h00004010, 0, 1, 32'h0,        0, 0, 1, 4'h0);
		set_row(7, `PCI_CMD_CFGRD, 32'h00001004, 1, 2, 32'h0,        2, 0, 1, 4'h0);
		set_row(8, `PCI_CMD_MEMRD, 32'h00005000, 0, 3, 32'h0,        1, 3, 1, 4'h0);
		set_row(9, `PCI_CMD_CFGRD, 32'h00022529, 0, 2, 32'h0,        0, 2, 1, 4'h0);
		cycle_limit = 50;
		for (r = 0; r < NROWS; r++)
			cycle_limit = cycle_limit + row_burst[r] * (row_lat[r] + row_bp[r] + 4);

		repeat (4) @(posedge PCI_CLK);
		PCI_RSTn <= 1'b1;
		repeat (3) begin // Idle bus after reset
			@(negedge PCI_CLK);
			check_value("devsel_n after reset", devsel_n, 1'b1);
			check_value("trdy_n after reset", trdy_n, 1'b1);
			check_value("ad_oe after reset", ad_oe, 1'b0);
		end
		check_value("strobes before first frame", n_rd + n_wr, 0);

		for (r = 0; r < NROWS; r++)
			run_row(r);

		$display("Checks done, %0d errors", errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/pci_target_properties.sv */
// PCI target bus assertions
`timescale 1ns/1ns
`default_nettype none

`include "pci_target_params.svh"

module pci_target_properties (
	input wire                 PCI_CLK,
	input wire                 PCI_RSTn,
	input wire [`PCI_ST_W-1:0] state,
	input wire                 devsel_n,
	input wire                 trdy_n,
	input wire                 ad_oe,
	input wire                 read_phase,
	input wire                 cfg_read,
	input wire                 mem_read,
	input wire                 cfg_write,
	input wire                 mem_write
);

	// Target ready only inside a claimed transaction
	a_trdy_devsel: assert property (@(posedge PCI_CLK) disable iff (!PCI_RSTn)
		!trdy_n |-> !devsel_n)
		else $error("trdy_n low while devsel_n high");

	// One direction per transaction
	a_rd_wr_excl: assert property (@(posedge PCI_CLK) disable iff (!PCI_RSTn)
		!((cfg_read | mem_read) && (cfg_write | mem_write)))
		else $error("read and write strobes in one cycle");

	// AD is driven only in read data phases that follow the turnaround cycle
	a_oe_read: assert property (@(posedge PCI_CLK) disable iff (!PCI_RSTn)
		ad_oe |-> read_phase &&
			($past(state) == `PCI_ST_TURN || $past(state) == `PCI_ST_READ))
		else $error("ad_oe high outside a read data phase after turnaround");

endmodule

bind pci_target_top pci_target_properties u_props (
	.PCI_CLK(PCI_CLK), .PCI_RSTn(PCI_RSTn), .state(u_ctrl.state),
	.devsel_n(devsel_n), .trdy_n(trdy_n), .ad_oe(ad_oe), .read_phase(read_phase),
	.cfg_read(cfg_read), .mem_read(mem_read),
	.cfg_write(cfg_write), .mem_write(mem_write)
);

`default_nettype wire

/* rtl/pci_target_top.sv */
// PCI target core top level
`timescale 1ns/1ns
`default_nettype none

`include "pci_target_params.svh"

module pci_target_top (
	input  wire                  PCI_CLK,
	input  wire                  PCI_RSTn,
	// ==============================
	// PCI bus, pads outside
	// ==============================
	input  wire                  frame_n,
	input  wire                  irdy_n,
	input  wire                  idsel,
	input  wire [`PCI_CBE_W-1:0] cbe_n,
	input  wire [`PCI_AD_W-1:0]  ad_in,
	output wire                  devsel_n,
	output wire                  trdy_n,
	output wire [`PCI_AD_W-1:0]  ad_out,
	output wire                  ad_oe,
	// ==============================
	// Configuration space port
	// ==============================
	output wire                  cfg_read,
	output wire                  cfg_write,
	output wire [1:0]            cfg_type,
	output wire [5:0]            cfg_dwnum,
	output wire [2:0]            cfg_func,
	output wire [4:0]            cfg_dev,
	output wire [7:0]            cfg_bus,
	output wire [`PCI_CBE_W-1:0] cfg_cbe_n,
	output wire [`PCI_AD_W-1:0]  cfg_writedata,
	input  wire [`PCI_AD_W-1:0]  cfg_readdata,
	input  wire                  cfg_readdatavalid,
	// ==============================
	// Memory space port
	// ==============================
	output wire                  mem_read,
	output wire                  mem_write,
	output wire [`PCI_AD_W-1:0]  mem_addr,
	output wire [`PCI_CBE_W-1:0] mem_cbe_n,
	output wire [`PCI_AD_W-1:0]  mem_writedata,
	input  wire [`PCI_AD_W-1:0]  mem_readdata,
	input  wire                  mem_readdatavalid
);

	wire pci_target_pkg::pci_addr_word_u addr_word; // Live address phase decode
	wire req_latch;
	wire req_advance;
	wire req_is_cfg;
	wire read_phase;
	wire beat_done;
	wire read_is_cfg;
	wire beat_ready;

	// Byte enables and write data go straight through in the data phase
	assign cfg_cbe_n     = cbe_n;
	assign mem_cbe_n     = cbe_n;
	assign cfg_writedata = ad_in;
	assign mem_writedata = ad_in;

	pci_target_ctrl u_ctrl (
		.PCI_CLK(PCI_CLK), .PCI_RSTn(PCI_RSTn),
		.frame_n(frame_n), .irdy_n(irdy_n), .idsel(idsel), .cbe_n(cbe_n),
		.addr_word(addr_word), .beat_ready(beat_ready),
		.devsel_n(devsel_n), .trdy_n(trdy_n), .ad_oe(ad_oe),
		.req_latch(req_latch), .req_advance(req_advance), .req_is_cfg(req_is_cfg),
		.read_phase(read_phase), .beat_done(beat_done), .read_is_cfg(read_is_cfg),
		.cfg_read(cfg_read), .cfg_write(cfg_write),
		.mem_read(mem_read), .mem_write(mem_write)
	);

	pci_req_addr u_addr (
		.PCI_CLK(PCI_CLK), .PCI_RSTn(PCI_RSTn), .ad_in(ad_in),
		.req_latch(req_latch), .req_advance(req_advance), .req_is_cfg(req_is_cfg),
		.addr_word(addr_word),
		.cfg_type(cfg_type), .cfg_dwnum(cfg_dwnum), .cfg_func(cfg_func),
		.cfg_dev(cfg_dev), .cfg_bus(cfg_bus), .mem_addr(mem_addr)
	);

	pci_read_hold u_hold (
		.PCI_CLK(PCI_CLK), .PCI_RSTn(PCI_RSTn),
		.read_phase(read_phase), .read_is_cfg(read_is_cfg), .beat_done(beat_done),
		.cfg_readdata(cfg_readdata), .cfg_readdatavalid(cfg_readdatavalid),
		.mem_readdata(mem_readdata), .mem_readdatavalid(mem_readdatavalid),
		.beat_ready(beat_ready), .ad_out(ad_out)
	);

endmodule

`default_nettype wire

/* rtl/pci_read_hold.sv */
// PCI read data hold and AD output
`timescale 1ns/1ns
`default_nettype none

`include "pci_target_params.svh"

module pci_read_hold (
	input  wire                  PCI_CLK,
	input  wire                  PCI_RSTn,
	input  wire                  read_phase,  // FSM in read data state
	input  wire                  read_is_cfg, // Select config return path
	input  wire                  beat_done,   // IRDY and TRDY both low
	input  wire [`PCI_AD_W-1:0]  cfg_readdata,
	input  wire                  cfg_readdatavalid,
	input  wire [`PCI_AD_W-1:0]  mem_readdata,
	input  wire                  mem_readdatavalid,
	output logic                 beat_ready,
	output logic [`PCI_AD_W-1:0] ad_out
);

	logic [`PCI_AD_W-1:0] live_data;
	logic                 live_valid;
	logic [`PCI_AD_W-1:0] held_data;
	logic                 held_valid;
	logic                 capture;

	// ==============================
	// Live return path
	// ==============================
	// Only one space is active per transaction
	assign live_data  = read_is_cfg ? cfg_readdata : mem_readdata;
	assign live_valid = read_is_cfg ? cfg_readdatavalid : mem_readdatavalid;

	// Data arrived but the initiator is not ready yet
	assign capture = read_phase & live_valid & ~beat_done & ~held_valid;

	// ==============================
	// Hold register
	// ==============================
	always_ff @(posedge PCI_CLK or negedge PCI_RSTn) begin
		if (!PCI_RSTn)
			held_valid <= 1'b0;
		else if (beat_done)
			held_valid <= 1'b0; // Beat taken, free for the next one
		else if (capture)
			held_valid <= 1'b1;
	end

	always_ff @(posedge PCI_CLK) begin
		if (capture)
			held_data <= live_data;
	end

	// ==============================
	// Outputs
	// ==============================
	assign beat_ready = held_valid | live_valid;

	// Held copy wins, downstream valid is only a pulse
	assign ad_out = held_valid ? held_data : live_data;

endmodule

`default_nettype wire

/* rtl/pci_req_addr.sv */
// PCI request address register
`timescale 1ns/1ns
`default_nettype none

`include "pci_target_params.svh"

module pci_req_addr (
	input  wire                               PCI_CLK,
	input  wire                               PCI_RSTn,
	input  wire [`PCI_AD_W-1:0]               ad_in,
	input  wire                               req_latch,   // Address phase
	input  wire                               req_advance, // Next beat of a burst
	input  wire                               req_is_cfg,  // Step dword number, not bytes
	output pci_target_pkg::pci_addr_word_u    addr_word,   // Live decode for the claim
	output logic [1:0]                        cfg_type,
	output logic [5:0]                        cfg_dwnum,
	output logic [2:0]                        cfg_func,
	output logic [4:0]                        cfg_dev,
	output logic [7:0]                        cfg_bus,
	output logic [`PCI_AD_W-1:0]              mem_addr
);

	pci_target_pkg::pci_addr_word_u addr_q; // Stored address phase word

	// Controller decodes the word still on the bus
	assign addr_word = ad_in;

	// ==============================
	// Latch and burst advance
	// ==============================
	always_ff @(posedge PCI_CLK or negedge PCI_RSTn) begin
		if (!PCI_RSTn) begin
			addr_q <= '0;
		end else if (req_latch) begin
			addr_q <= ad_in;
		end else if (req_advance) begin
			if (req_is_cfg)
				addr_q.cfg.dwnum <= addr_q.cfg.dwnum + 6'd1; // Wraps inside the function
			else
				addr_q.mem <= addr_q.mem + `PCI_MEM_STEP;
		end
	end

	// ==============================
	// Downstream views
	// ==============================
	assign cfg_type  = addr_q.cfg.cfg_type;
	assign cfg_dwnum = addr_q.cfg.dwnum;
	assign cfg_func  = addr_q.cfg.func;
	assign cfg_dev   = addr_q.cfg.dev;
	assign cfg_bus   = addr_q.cfg.bus;
	assign mem_addr  = addr_q.mem; // Byte address, low bits as given by the initiator

endmodule

`default_nettype wire

/* rtl/pci_target_ctrl.sv */
// PCI target transaction control
// Claim decode, FSM and handshake
`timescale 1ns/1ns
`default_nettype none

`include "pci_target_params.svh"

module pci_target_ctrl (
	input  wire                              PCI_CLK,
	input  wire                              PCI_RSTn,
	// Bus side
	input  wire                              frame_n,
	input  wire                              irdy_n,
	input  wire                              idsel,
	input  wire [`PCI_CBE_W-1:0]             cbe_n,
	input  wire pci_target_pkg::pci_addr_word_u addr_word, // Live AD decode
	input  wire                              beat_ready,  // Read data available
	output logic                             devsel_n,
	output logic                             trdy_n,
	output logic                             ad_oe,
	// Address register control
	output logic                             req_latch,
	output logic                             req_advance,
	output logic                             req_is_cfg,
	// Read hold control
	output logic                             read_phase,
	output logic                             beat_done,
	output logic                             read_is_cfg,
	// Downstream strobes
	output logic                             cfg_read,
	output logic                             cfg_write,
	output logic                             mem_read,
	output logic                             mem_write
);

	logic [`PCI_ST_W-1:0]  state;
	logic [`PCI_ST_W-1:0]  next_state;
	logic [`PCI_CBE_W-1:0] cmd;       // Command of the claimed transaction
	logic                  frame_q;   // frame_n one cycle back
	logic                  frame_start;
	logic                  cfg_hit;
	logic                  cmd_is_cfg;
	logic                  cmd_is_read;
	logic                  cmd_is_write;

	// ==============================
	// Decode
	// ==============================
	assign frame_start = frame_q & ~frame_n; // Address phase only on the falling edge

	// Type 0 needs IDSEL, type 1 is taken regardless
	assign cfg_hit = ((addr_word.cfg.cfg_type == 2'b00) && idsel) ||
	                 (addr_word.cfg.cfg_type == 2'b01);

	assign cmd_is_cfg   = (cmd == `PCI_CMD_CFGRD) || (cmd == `PCI_CMD_CFGWR);
	assign cmd_is_read  = (cmd == `PCI_CMD_CFGRD) || (cmd == `PCI_CMD_MEMRD);
	assign cmd_is_write = (cmd == `PCI_CMD_CFGWR) || (cmd == `PCI_CMD_MEMWR);

	// ==============================
	// Handshake lines
	// ==============================
	assign devsel_n    = (state == `PCI_ST_IDLE); // Held for the whole claimed transaction
	assign read_phase  = (state == `PCI_ST_READ);
	assign ad_oe       = read_phase; // Turnaround cycle leaves AD undriven
	assign req_is_cfg  = cmd_is_cfg;
	assign read_is_cfg = (cmd == `PCI_CMD_CFGRD);

	always_comb begin
		case (state)
			`PCI_ST_WRITE: trdy_n = 1'b0;        // Writes never wait
			`PCI_ST_READ:  trdy_n = ~beat_ready; // Wait for downstream data
			default:       trdy_n = 1'b1;
		endcase
	end

	assign beat_done = ~irdy_n & ~trdy_n; // Data phase completes

	// ==============================
	// Next state and strobes
	// ==============================
	always_comb begin
		next_state  = state;
		req_latch   = 1'b0;
		req_advance = 1'b0;
		cfg_read    = 1'b0;
		cfg_write   = 1'b0;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		case (state)
			`PCI_ST_IDLE: begin
				if (frame_start) begin
					req_latch = 1'b1; // Address and command taken on every start
					case (cbe_n)
						`PCI_CMD_CFGRD: if (cfg_hit) next_state = `PCI_ST_TURN;
						`PCI_CMD_CFGWR: if (cfg_hit) next_state = `PCI_ST_WRITE;
						`PCI_CMD_MEMRD: next_state = `PCI_ST_TURN;
						`PCI_CMD_MEMWR: next_state = `PCI_ST_WRITE;
						default:        next_state = `PCI_ST_IDLE; // Not ours
					endcase
				end
			end
			`PCI_ST_TURN: begin
				if (cmd_is_read) begin
					cfg_read    = cmd_is_cfg;  // First fetch
					mem_read    = ~cmd_is_cfg;
					req_advance = ~frame_n;    // Burst, point at the next dword
					next_state  = `PCI_ST_READ;
				end else begin
					next_state = `PCI_ST_IDLE;
				end
			end
			`PCI_ST_WRITE: begin
				if (!cmd_is_write) begin
					next_state = `PCI_ST_IDLE;
				end else if (beat_done) begin
					cfg_write = cmd_is_cfg;
					mem_write = ~cmd_is_cfg;
					if (frame_n)
						next_state = `PCI_ST_IDLE; // Last data phase
					else
						req_advance = 1'b1;
				end
			end
			`PCI_ST_READ: begin
				if (!cmd_is_read) begin
					next_state = `PCI_ST_IDLE;
				end else if (beat_done) begin
					if (frame_n) begin
						next_state = `PCI_ST_IDLE;
					end else begin
						// Fetch the following beat at the already advanced address
						cfg_read    = cmd_is_cfg;
						mem_read    = ~cmd_is_cfg;
						req_advance = 1'b1;
					end
				end
			end
			default: next_state = `PCI_ST_IDLE;
		endcase
	end

	// ==============================
	// State registers
	// ==============================
	always_ff @(posedge PCI_CLK or negedge PCI_RSTn) begin
		if (!PCI_RSTn) begin
			state   <= `PCI_ST_IDLE;
			cmd     <= '0;
			frame_q <= 1'b1; // Bus idle
		end else begin
			state   <= next_state;
			frame_q <= frame_n;
			if (req_latch)
				cmd <= cbe_n; // Keep the command for the data phases
		end
	end

endmodule

`default_nettype wire

/* rtl/pci_target_pkg.sv */
// PCI target shared types
`default_nettype none

`include "pci_target_params.svh"

package pci_target_pkg;

	// ==============================
	// Address phase word
	// ==============================
	// Configuration decode, MSB first
	// Type 0 carries device select via IDSEL, type 1 is routed by bus number
	typedef struct packed {
		logic [7:0] rsvd;     // Upper byte, unused
		logic [7:0] bus;      // Bus number
		logic [4:0] dev;      // Device number
		logic [2:0] func;     // Function number
		logic [5:0] dwnum;    // Register dword index
		logic [1:0] cfg_type; // 00 type 0, 01 type 1
	} pci_cfg_addr_s;

	// Same AD word seen as config fields or as a byte address
	typedef union packed {
		pci_cfg_addr_s        cfg; // Configuration cycles
		logic [`PCI_AD_W-1:0] mem; // Memory cycles
	} pci_addr_word_u;

endpackage

`default_nettype wire

/* rtl/pci_target_params.svh */
// PCI target core parameters
// Widths, commands and FSM codes
`ifndef PCI_TARGET_PARAMS_SVH
`define PCI_TARGET_PARAMS_SVH

// ==============================
// Bus widths
// ==============================
`define PCI_AD_W  32 // Multiplexed address/data
`define PCI_CBE_W 4  // Command in address phase, byte enables after

// ==============================
// Bus commands
// ==============================
// Only the four claimed commands, others are ignored
`define PCI_CMD_MEMRD 4'b0110 // Memory read
`define PCI_CMD_MEMWR 4'b0111 // Memory write
`define PCI_CMD_CFGRD 4'b1010 // Configuration read
`define PCI_CMD_CFGWR 4'b1011 // Configuration write

// ==============================
// Transaction FSM
// ==============================
`define PCI_ST_W     2
`define PCI_ST_IDLE  2'd0 // Waiting for an address phase
`define PCI_ST_TURN  2'd1 // Read turnaround, first fetch issued
`define PCI_ST_WRITE 2'd2 // Write data phases
`define PCI_ST_READ  2'd3 // Read data phases

// Memory address step per data phase, one dword
`define PCI_MEM_STEP 32'd4

`endif
